// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// pc after reset
`define RV_RESET_PC 64'h0

// memory mapped devices
// keyboard data register
`define RV_KEY_BASE 64'h8000_0010
// terminal (art) data register
`define RV_ART_BASE 64'h8000_0000

// machine csr numbers
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MIE     12'h304
`define RV_CSR_MIP     12'h344
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MCAUSE  12'h342

// csr bit positions
`define RV_MSTATUS_MIE_BIT 3
`define RV_MIE_MEIE_BIT    11
`define RV_MIP_MEIP_BIT    11

// interrupt flag in the top bit, code 11 = machine external
`define RV_MCAUSE_MEI 64'h8000_0000_0000_000b

// interrupt_vector code of the keyboard
`define RV_IRQ_KEYBOARD 4'd1

// major opcodes
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_SYSTEM 7'b1110011

// funct3 / funct7 values
`define RV_F3_ADD    3'b000
`define RV_F3_DOUBLE 3'b011
`define RV_F3_CSRRW  3'b001
`define RV_F3_CSRRS  3'b010
`define RV_F7_ADD    7'b0000000

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    // one integer register, or one bus doubleword
    typedef logic [63:0] xlen_t;

    // register file index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // request from execute to the bus master
    // none means no request this cycle
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_op_e;

    // major opcodes, bits [6:0] of the instruction word
    // only the groups the core decodes are listed
    // any other value falls through as a no-op
    typedef enum logic [6:0] {
        // lui rd, imm
        opc_lui    = `RV_OPC_LUI,
        // addi and friends
        opc_op_imm = `RV_OPC_OP_IMM,
        // add and friends
        opc_op     = `RV_OPC_OP,
        // ld
        opc_load   = `RV_OPC_LOAD,
        // sd
        opc_store  = `RV_OPC_STORE,
        // csrrw, csrrs
        opc_system = `RV_OPC_SYSTEM
    } opcode_e;

endpackage

// ==== hw/rv_fetch.sv ====
`include "rv_consts.svh"

module rv_fetch (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   instruction,
    input  logic          stall,
    output rv_pkg::xlen_t pc,
    output logic [31:0]   ir,
    output logic          ir_valid,
    output logic          heartbeat
);

    // pc and valid flag
    // both freeze while execute holds stall
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc       <= `RV_RESET_PC;
            ir_valid <= 1'b0;
        end else if (!stall) begin
            // word at pc moves into ir this edge
            pc       <= pc + 64'd4;
            ir_valid <= 1'b1;
        end
    end

    // instruction register
    // contents only matter once ir_valid is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            ir <= instruction;
        end
    end

    // liveness indicator
    // flips on every edge, stalled or not
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
        end
    end

endmodule

// ==== hw/rv_execute.sv ====
`include "rv_consts.svh"

module rv_execute (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        ir,
    input  logic               ir_valid,
    input  logic [3:0]         interrupt_vector,
    input  logic               busy,
    input  logic               load_done,
    input  rv_pkg::reg_idx_t   load_rd,
    input  rv_pkg::xlen_t      load_data,
    input  logic               irq_taken,
    output logic               stall,
    output rv_pkg::bus_op_e    req_op,
    output rv_pkg::xlen_t      req_adr,
    output rv_pkg::xlen_t      req_wdata,
    output rv_pkg::reg_idx_t   req_rd,
    output logic               irq_ok
);

    import rv_pkg::*;

    // instruction fields
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] csr_addr;
    xlen_t       imm_u;
    xlen_t       imm_i;
    xlen_t       imm_s;

    // decoded instruction kind
    logic is_lui;
    logic is_addi;
    logic is_add;
    logic is_ld;
    logic is_sd;
    logic is_csrrw;
    logic is_csrrs;
    logic mem_op;

    // x1..x31, x0 is never stored
    xlen_t regs [1:31];
    xlen_t rs1_val;
    xlen_t rs2_val;
    logic  rd_we;
    xlen_t rd_wdata;

    // csr file
    xlen_t mstatus;
    xlen_t mie;
    xlen_t mip;
    xlen_t mtvec;
    xlen_t mcause;
    xlen_t csr_rdata;
    xlen_t csr_wdata;
    logic  csr_we;

    // bus request already handed to the bus master
    logic issued;
    logic retire;

    assign opcode   = opcode_e'(ir[6:0]);
    assign rd       = ir[11:7];
    assign funct3   = ir[14:12];
    assign rs1      = ir[19:15];
    assign rs2      = ir[24:20];
    assign funct7   = ir[31:25];
    assign csr_addr = ir[31:20];

    // sign extended immediates
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};

    // decode, unknown words stay all zero and act as a no-op
    always_comb begin
        is_lui   = 1'b0;
        is_addi  = 1'b0;
        is_add   = 1'b0;
        is_ld    = 1'b0;
        is_sd    = 1'b0;
        is_csrrw = 1'b0;
        is_csrrs = 1'b0;
        if (ir_valid) begin
            case (opcode)
                opc_lui:    is_lui   = 1'b1;
                opc_op_imm: is_addi  = (funct3 == `RV_F3_ADD);
                opc_op:     is_add   = (funct3 == `RV_F3_ADD) && (funct7 == `RV_F7_ADD);
                opc_load:   is_ld    = (funct3 == `RV_F3_DOUBLE);
                opc_store:  is_sd    = (funct3 == `RV_F3_DOUBLE);
                opc_system: begin
                    is_csrrw = (funct3 == `RV_F3_CSRRW);
                    is_csrrs = (funct3 == `RV_F3_CSRRS);
                end
                default: ;
            endcase
        end
    end

    assign mem_op = is_ld || is_sd;

    // register reads, x0 reads zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // issue once, then wait for the bus master to finish
    assign req_op    = (mem_op && !issued && !busy) ? (is_ld ? bus_load : bus_store) : bus_none;
    assign req_adr   = rs1_val + (is_sd ? imm_s : imm_i);
    assign req_wdata = rs2_val;
    assign req_rd    = rd;

    // hold fetch while a request waits or the bus is working
    assign stall  = (mem_op && !issued) || busy;
    assign retire = ir_valid && !stall;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issued <= 1'b0;
        end else if (req_op != bus_none) begin
            issued <= 1'b1;
        end else if (!stall) begin
            // ir moves on, next instruction starts fresh
            issued <= 1'b0;
        end
    end

    // result of the instruction in ir
    assign rd_we = is_lui || is_addi || is_add || is_csrrw || is_csrrs;

    always_comb begin
        if (is_lui) begin
            rd_wdata = imm_u;
        end else if (is_addi) begin
            rd_wdata = rs1_val + imm_i;
        end else if (is_add) begin
            rd_wdata = rs1_val + rs2_val;
        end else begin
            // csr instructions return the old csr value
            rd_wdata = csr_rdata;
        end
    end

    // one write port, load return or retiring instruction
    // an ld still sits in ir during load_done so the two never meet
    always_ff @(posedge clk) begin
        if (load_done && (load_rd != 5'd0)) begin
            regs[load_rd] <= load_data;
        end else if (retire && rd_we && (rd != 5'd0)) begin
            regs[rd] <= rd_wdata;
        end
    end

    // external interrupt pending while the keyboard code is present
    always_comb begin
        mip = '0;
        mip[`RV_MIP_MEIP_BIT] = (interrupt_vector == `RV_IRQ_KEYBOARD);
    end

    always_comb begin
        case (csr_addr)
            `RV_CSR_MSTATUS: csr_rdata = mstatus;
            `RV_CSR_MIE:     csr_rdata = mie;
            `RV_CSR_MIP:     csr_rdata = mip;
            `RV_CSR_MTVEC:   csr_rdata = mtvec;
            `RV_CSR_MCAUSE:  csr_rdata = mcause;
            default:         csr_rdata = '0;
        endcase
    end

    // csrrs with rs1 = x0 only reads
    assign csr_wdata = is_csrrw ? rs1_val : (csr_rdata | rs1_val);
    assign csr_we    = retire && (is_csrrw || (is_csrrs && (rs1 != 5'd0)));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mcause  <= '0;
        end else begin
            if (csr_we) begin
                // mip and unknown numbers drop the write
                case (csr_addr)
                    `RV_CSR_MSTATUS: mstatus <= csr_wdata;
                    `RV_CSR_MIE:     mie     <= csr_wdata;
                    `RV_CSR_MTVEC:   mtvec   <= csr_wdata;
                    `RV_CSR_MCAUSE:  mcause  <= csr_wdata;
                    default: ;
                endcase
            end
            // serviced interrupt records its cause
            if (irq_taken) begin
                mcause <= `RV_MCAUSE_MEI;
            end
        end
    end

    // global and external enable, the bus master decides the rest
    assign irq_ok = mstatus[`RV_MSTATUS_MIE_BIT] && mie[`RV_MIE_MEIE_BIT];

endmodule

// ==== hw/rv_bus_master.sv ====
`include "rv_consts.svh"

module rv_bus_master (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::bus_op_e  req_op,
    input  rv_pkg::xlen_t    req_adr,
    input  rv_pkg::xlen_t    req_wdata,
    input  rv_pkg::reg_idx_t req_rd,
    input  logic             irq_ok,
    input  logic [3:0]       interrupt_vector,
    output logic             busy,
    output logic             load_done,
    output rv_pkg::reg_idx_t load_rd,
    output rv_pkg::xlen_t    load_data,
    output logic             irq_taken,
    output logic             interrupt_done,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output rv_pkg::xlen_t    wb_adr,
    output logic [7:0]       wb_sel,
    output rv_pkg::xlen_t    wb_dat_w,
    input  rv_pkg::xlen_t    wb_dat_r,
    input  logic             wb_ack
);

    import rv_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_core,
        st_key_rd,
        st_art_wr
    } state_e;

    state_e state;

    logic start_core;
    logic take_irq;
    logic core_ack;
    logic key_ack;
    logic art_start;
    logic art_ack;

    // requests win over the interrupt in the same cycle
    assign start_core = (state == st_idle) && (req_op != bus_none);
    assign take_irq   = (state == st_idle) && (req_op == bus_none) && irq_ok &&
                        (interrupt_vector == `RV_IRQ_KEYBOARD);

    // ack only counts while the cycle is open
    assign core_ack  = (state == st_core) && wb_cyc && wb_ack;
    assign key_ack   = (state == st_key_rd) && wb_cyc && wb_ack;
    // one idle cycle between the key read and the art write
    assign art_start = (state == st_art_wr) && !wb_cyc;
    assign art_ack   = (state == st_art_wr) && wb_cyc && wb_ack;

    assign busy   = (state != st_idle);
    // doubleword accesses only
    assign wb_sel = 8'hff;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state          <= st_idle;
            wb_cyc         <= 1'b0;
            wb_stb         <= 1'b0;
            wb_we          <= 1'b0;
            load_done      <= 1'b0;
            irq_taken      <= 1'b0;
            interrupt_done <= 1'b0;
        end else begin
            // single cycle pulses
            load_done      <= 1'b0;
            irq_taken      <= 1'b0;
            interrupt_done <= 1'b0;
            if (start_core) begin
                state  <= st_core;
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= (req_op == bus_store);
            end else if (take_irq) begin
                // copy starts with the keyboard read
                state  <= st_key_rd;
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= 1'b0;
            end else if (core_ack) begin
                state     <= st_idle;
                wb_cyc    <= 1'b0;
                wb_stb    <= 1'b0;
                load_done <= !wb_we;
            end else if (key_ack) begin
                state  <= st_art_wr;
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we  <= 1'b1;
            end else if (art_start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end else if (art_ack) begin
                // copy finished, report to execute and outside
                state          <= st_idle;
                wb_cyc         <= 1'b0;
                wb_stb         <= 1'b0;
                irq_taken      <= 1'b1;
                interrupt_done <= 1'b1;
            end
        end
    end

    // address, write data and load return
    always_ff @(posedge clk) begin
        if (start_core) begin
            wb_adr   <= req_adr;
            wb_dat_w <= req_wdata;
            load_rd  <= req_rd;
        end else if (take_irq) begin
            wb_adr <= `RV_KEY_BASE;
        end else if (key_ack) begin
            // keyboard value goes straight back out to the terminal
            wb_adr   <= `RV_ART_BASE;
            wb_dat_w <= wb_dat_r;
        end
        if (core_ack) begin
            load_data <= wb_dat_r;
        end
    end

endmodule

// ==== hw/rv_core_top.sv ====
module rv_core_top (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   instruction,
    output rv_pkg::xlen_t pc,
    input  logic [3:0]    interrupt_vector,
    output logic          interrupt_done,
    output logic          heartbeat,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::xlen_t wb_adr,
    output logic [7:0]    wb_sel,
    output rv_pkg::xlen_t wb_dat_w,
    input  rv_pkg::xlen_t wb_dat_r,
    input  logic          wb_ack
);

    import rv_pkg::*;

    // fetch <-> execute
    logic [31:0] ir;
    logic        ir_valid;
    logic        stall;

    // execute -> bus master
    bus_op_e  req_op;
    xlen_t    req_adr;
    xlen_t    req_wdata;
    reg_idx_t req_rd;
    logic     irq_ok;

    // bus master -> execute
    logic     busy;
    logic     load_done;
    reg_idx_t load_rd;
    xlen_t    load_data;
    logic     irq_taken;

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .stall       (stall),
        .pc          (pc),
        .ir          (ir),
        .ir_valid    (ir_valid),
        .heartbeat   (heartbeat)
    );

    rv_execute u_execute (
        .clk              (clk),
        .reset            (reset),
        .ir               (ir),
        .ir_valid         (ir_valid),
        .interrupt_vector (interrupt_vector),
        .busy             (busy),
        .load_done        (load_done),
        .load_rd          (load_rd),
        .load_data        (load_data),
        .irq_taken        (irq_taken),
        .stall            (stall),
        .req_op           (req_op),
        .req_adr          (req_adr),
        .req_wdata        (req_wdata),
        .req_rd           (req_rd),
        .irq_ok           (irq_ok)
    );

    rv_bus_master u_bus_master (
        .clk              (clk),
        .reset            (reset),
        .req_op           (req_op),
        .req_adr          (req_adr),
        .req_wdata        (req_wdata),
        .req_rd           (req_rd),
        .irq_ok           (irq_ok),
        .interrupt_vector (interrupt_vector),
        .busy             (busy),
        .load_done        (load_done),
        .load_rd          (load_rd),
        .load_data        (load_data),
        .irq_taken        (irq_taken),
        .interrupt_done   (interrupt_done),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_sel           (wb_sel),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack)
    );

endmodule

// ==== dv/rv_core_tb.sv ====
`include "rv_consts.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] pc;
    logic [3:0]  interrupt_vector;
    logic        interrupt_done;
    logic        heartbeat;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [63:0] wb_adr;
    logic [7:0]  wb_sel;
    logic [63:0] wb_dat_w;
    logic [63:0] wb_dat_r;
    logic        wb_ack;

    // three trace words per record as kind a b
    logic [63:0] trace_mem [0:191];
    logic [31:0] prog [0:63];
    int          prog_len;
    logic        exp_we  [0:63];
    logic [63:0] exp_adr [0:63];
    logic [63:0] exp_dat [0:63];
    int          exp_count;
    int          exp_pos;
    logic [63:0] irq_index;
    logic [3:0]  irq_vec;
    logic        irq_raised;

    int          errors;
    int          done_count;
    int          txn_count;
    logic        timed_out;
    logic [31:0] lfsr;
    logic        slave_active;
    int          slave_wait;
    logic [63:0] last_adr;
    logic        prev_hb;

    rv_core_top dut (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .interrupt_vector (interrupt_vector),
        .interrupt_done   (interrupt_done),
        .heartbeat        (heartbeat),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_sel           (wb_sel),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two bits with one lfsr step per bit
    task automatic draw_delay(output int d);
        logic b0;
        logic b1;
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d = int'({b1, b0});
    endtask

    task automatic load_trace();
        int   i;
        logic stop;
        logic [63:0] kind;
        logic [63:0] a;
        logic [63:0] b;
        stop = 1'b0;
        for (i = 0; i < 192; i++) begin
            trace_mem[i] = '0;
        end
        for (i = 0; i < 64; i++) begin
            prog[i] = 32'h0000_0013;
        end
        $readmemh("dv/rv_core_trace.txt", trace_mem);
        for (i = 0; i < 64 && !stop; i++) begin
            kind = trace_mem[3 * i];
            a    = trace_mem[3 * i + 1];
            b    = trace_mem[3 * i + 2];
            case (kind)
                64'd1: begin
                    prog[a[7:2]] = b[31:0];
                    prog_len++;
                end
                64'd2: begin
                    irq_index = a;
                    irq_vec   = b[3:0];
                end
                64'd3, 64'd4: begin
                    // 3 is a read to answer and 4 a write to compare
                    exp_we[exp_count]  = (kind == 64'd4);
                    exp_adr[exp_count] = a;
                    exp_dat[exp_count] = b;
                    exp_count++;
                end
                default: stop = 1'b1;
            endcase
        end
    endtask

    // one slave transfer compared in order with the trace
    task automatic complete_transaction();
        last_adr = wb_adr;
        txn_count++;
        if (exp_pos >= exp_count) begin
            errors++;
            $display("unexpected bus access at address %h after the expected list ended",
                     wb_adr);
            wb_dat_r = '0;
        end else begin
            check_value("wb_we", 64'(wb_we), 64'(exp_we[exp_pos]));
            check_value("wb_adr", wb_adr, exp_adr[exp_pos]);
            check_value("wb_sel", 64'(wb_sel), 64'hff);
            if (exp_we[exp_pos]) begin
                check_value("wb_dat_w", wb_dat_w, exp_dat[exp_pos]);
                wb_dat_r = '0;
            end else begin
                wb_dat_r = exp_dat[exp_pos];
            end
            exp_pos++;
        end
    endtask

    // ack after 0..3 falling edges of random delay
    task automatic slave_step();
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!slave_active) begin
                slave_active = 1'b1;
                draw_delay(slave_wait);
            end
            if (slave_wait == 0) begin
                complete_transaction();
                wb_ack       = 1'b1;
                slave_active = 1'b0;
            end else begin
                slave_wait--;
            end
        end
    endtask

    task automatic drive_cycle();
        // liveness
        check_value("heartbeat", 64'(heartbeat), 64'(!prev_hb));
        prev_hb = heartbeat;
        // pulse must follow the terminal write
        if (interrupt_done) begin
            done_count++;
            check_value("last wb_adr before interrupt_done", last_adr, `RV_ART_BASE);
            interrupt_vector = 4'd0;
        end
        if (!irq_raised && pc == (irq_index << 2)) begin
            interrupt_vector = irq_vec;
            irq_raised       = 1'b1;
        end
        slave_step();
        // instruction memory with nop outside the program
        if (pc < 64'(prog_len * 4)) begin
            instruction = prog[pc[7:2]];
        end else begin
            instruction = 32'h0000_0013;
        end
    endtask

    initial begin
        int   cycles;
        logic finished;
        clk              = 1'b0;
        reset            = 1'b0;
        instruction      = 32'h0000_0013;
        interrupt_vector = 4'd0;
        wb_dat_r         = '0;
        wb_ack           = 1'b0;
        errors           = 0;
        done_count       = 0;
        txn_count        = 0;
        timed_out        = 1'b0;
        lfsr             = 32'hf552_b9bb;
        slave_active     = 1'b0;
        slave_wait       = 0;
        last_adr         = '0;
        prog_len         = 0;
        exp_count        = 0;
        exp_pos          = 0;
        irq_index        = 64'hffff;
        irq_vec          = 4'd0;
        irq_raised       = 1'b0;
        load_trace();

        repeat (3) @(posedge clk);
        @(negedge clk);
        // reset state
        check_value("pc", pc, `RV_RESET_PC);
        check_value("wb_cyc", 64'(wb_cyc), 64'd0);
        check_value("wb_stb", 64'(wb_stb), 64'd0);
        check_value("interrupt_done", 64'(interrupt_done), 64'd0);
        reset       = 1'b1;
        instruction = prog[0];
        prev_hb     = heartbeat;

        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < 4000) begin
            @(negedge clk);
            cycles++;
            drive_cycle();
            finished = (exp_pos == exp_count) && !wb_cyc &&
                       (pc >= 64'((prog_len + 2) * 4));
        end
        if (!finished) begin
            timed_out = 1'b1;
            $display("timeout: the program did not finish within %0d cycles", cycles);
        end
        check_value("interrupt_done pulses", 64'(done_count), 64'd1);

        $display("errors: %0d, bus transactions: %0d of %0d expected, interrupt pulses: %0d",
                 errors, txn_count, exp_count, done_count);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/rv_core_trace.txt ====
// kind a b: 1 program (address, word), 2 irq (program index, vector)
// 3 expected read (address, data to return), 4 expected write (address, data)
1 0 00001537
1 4 800000b7
1 8 fff00113
1 c 002081b3
1 10 00210213
1 14 00153023
1 18 00353423
1 1c 00453823
1 20 00053c23
1 24 02053283
1 28 02553423
1 2c 30509073
1 30 30502373
1 34 02653823
1 38 7c002273
1 3c 02453c23
1 40 40000413
1 44 00840433
1 48 30441073
1 4c 00000013
1 50 344024f3
1 54 04953023
1 58 00800593
1 5c 30059073
1 60 00000013
1 64 00000013
1 68 34202673
1 6c 04c53423
2 13 1
4 1000 ffffffff80000000
4 1008 ffffffff7fffffff
4 1010 1
4 1018 0
3 1020 0123456789abcdef
4 1028 0123456789abcdef
4 1030 ffffffff80000000
4 1038 0
4 1040 800
3 80000010 a5
4 80000000 a5
4 1048 800000000000000b

// ==== files.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_execute.sv
hw/rv_bus_master.sv
hw/rv_core_top.sv
dv/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f files.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi

if ! grep -q "all tests passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
